//--- neuro_emu.f
+incdir+tests
rtl/neuro_pkg.sv
rtl/neuro_reg_decode.sv
rtl/neuro_tick_gen.sv
rtl/neuro_mn_pool.sv
rtl/neuro_spike_emg.sv
rtl/neuro_emu_top.sv
tests/neuro_tb.sv

//--- rtl/neuro_emu_top.sv
`timescale 1ns/100ps

module neuro_emu_top #(
    parameter int EMG_SHIFT = 3
) (
    input  logic                                i_ep50trig,
    input  logic                                i_reset_global,
    // axi4-lite slave
    input  logic [neuro_pkg::AXI_ADDR_W-1:0]    i_awaddr,
    input  logic                                i_awvalid,
    output logic                                o_awready,
    input  logic [neuro_pkg::AXI_DATA_W-1:0]    i_wdata,
    input  logic [neuro_pkg::AXI_DATA_W/8-1:0]  i_wstrb,
    input  logic                                i_wvalid,
    output logic                                o_wready,
    output logic                                o_bvalid,
    output neuro_pkg::axi_resp_t                o_bresp,
    input  logic                                i_bready,
    input  logic [neuro_pkg::AXI_ADDR_W-1:0]    i_araddr,
    input  logic                                i_arvalid,
    output logic                                o_arready,
    output logic                                o_rvalid,
    output logic [neuro_pkg::AXI_DATA_W-1:0]    o_rdata,
    output neuro_pkg::axi_resp_t                o_rresp,
    input  logic                                i_rready,
    // cross-board spikes
    input  logic                                i_spike_in,
    output logic                                o_spike_out
);

    logic                  run;
    neuro_pkg::half_cnt_t  half_cnt;
    neuro_pkg::gain_t      gain;
    neuro_pkg::membrane_t  thresh;
    neuro_pkg::drive_t     drive;
    logic                  tick;
    logic                  mn_spike;
    neuro_pkg::spike_cnt_t mn_cnt;
    neuro_pkg::spike_cnt_t ll_cnt;
    neuro_pkg::spike_cnt_t comb_cnt;
    neuro_pkg::emg_t       emg;

    ////////////////////////////////////////////////////////////
    // decode, registers and bus
    ////////////////////////////////////////////////////////////
    neuro_reg_decode neuro_reg_decode_inst (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_awaddr       (i_awaddr),
        .i_awvalid      (i_awvalid),
        .o_awready      (o_awready),
        .i_wdata        (i_wdata),
        .i_wstrb        (i_wstrb),
        .i_wvalid       (i_wvalid),
        .o_wready       (o_wready),
        .o_bvalid       (o_bvalid),
        .o_bresp        (o_bresp),
        .i_bready       (i_bready),
        .i_araddr       (i_araddr),
        .i_arvalid      (i_arvalid),
        .o_arready      (o_arready),
        .o_rvalid       (o_rvalid),
        .o_rdata        (o_rdata),
        .o_rresp        (o_rresp),
        .i_rready       (i_rready),
        .o_run          (run),
        .o_half_cnt     (half_cnt),
        .o_gain         (gain),
        .o_thresh       (thresh),
        .o_drive        (drive),
        .i_mn_cnt       (mn_cnt),
        .i_ll_cnt       (ll_cnt),
        .i_comb_cnt     (comb_cnt),
        .i_emg          (emg)
    );

    // sim tick
    neuro_tick_gen neuro_tick_gen_inst (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_run          (run),
        .i_half_cnt     (half_cnt),
        .o_tick         (tick)
    );

    ////////////////////////////////////////////////////////////
    // execute and result
    ////////////////////////////////////////////////////////////
    neuro_mn_pool neuro_mn_pool_inst (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_run          (run),
        .i_drive        (drive),
        .i_gain         (gain),
        .i_thresh       (thresh),
        .o_spike        (mn_spike)
    );

    neuro_spike_emg #(
        .EMG_SHIFT (EMG_SHIFT)
    ) neuro_spike_emg_inst (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_run          (run),
        .i_tick         (tick),
        .i_mn_spike     (mn_spike),
        .i_ll_spike     (i_spike_in),
        .o_mn_cnt       (mn_cnt),
        .o_ll_cnt       (ll_cnt),
        .o_comb_cnt     (comb_cnt),
        .o_emg          (emg)
    );

    // motoneuron train to the next board
    assign o_spike_out = mn_spike;

endmodule

//--- rtl/neuro_mn_pool.sv
`timescale 1ns/100ps

module neuro_mn_pool (
    input  logic                 i_ep50trig,
    input  logic                 i_reset_global,
    input  logic                 i_run,
    input  neuro_pkg::drive_t    i_drive,
    input  neuro_pkg::gain_t     i_gain,
    input  neuro_pkg::membrane_t i_thresh,
    output logic                 o_spike
);

    // headroom for membrane plus a full scale product
    localparam int ACC_W = 34;

    localparam logic signed [ACC_W-1:0] MEM_MAX = 34'sh0_7FFF_FFFF;

    neuro_pkg::membrane_t    mem_q;
    logic signed [32:0]      prod;
    logic signed [ACC_W-1:0] sum;
    logic signed [ACC_W-1:0] mem_next;
    logic                    fire;

    ////////////////////////////////////////////////////////////
    // integrate and fire
    ////////////////////////////////////////////////////////////
    // unsigned drive times signed gain
    assign prod = $signed({1'b0, i_drive}) * i_gain;

    always_comb
    begin
        sum  = ACC_W'(mem_q) + ACC_W'(prod);
        fire = (sum >= ACC_W'(i_thresh));
        // subtract on fire
        if (fire)
        begin
            mem_next = sum - ACC_W'(i_thresh);
        end
        else
        begin
            mem_next = sum;
        end
        // floor at 0
        if (mem_next < 0)
        begin
            mem_next = '0;
        end
        // large gains could run past 32 bits
        else if (mem_next > MEM_MAX)
        begin
            mem_next = MEM_MAX;
        end
    end

    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global || !i_run)
        begin
            mem_q   <= '0;
            o_spike <= 1'b0;
        end
        else
        begin
            mem_q   <= mem_next[31:0];
            o_spike <= fire;
        end
    end

endmodule

//--- rtl/neuro_pkg.sv
package neuro_pkg;

    ////////////////////////////////////////////////////////////
    // bus widths and response codes
    ////////////////////////////////////////////////////////////
    localparam int AXI_ADDR_W = 8;
    localparam int AXI_DATA_W = 32;

    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    ////////////////////////////////////////////////////////////
    // register map, byte offsets
    ////////////////////////////////////////////////////////////
    // host writable
    localparam logic [AXI_ADDR_W-1:0] ADDR_CTRL     = 8'h00;
    localparam logic [AXI_ADDR_W-1:0] ADDR_HALF_CNT = 8'h04;
    localparam logic [AXI_ADDR_W-1:0] ADDR_GAIN     = 8'h08;
    localparam logic [AXI_ADDR_W-1:0] ADDR_THRESH   = 8'h0C;
    localparam logic [AXI_ADDR_W-1:0] ADDR_DRIVE    = 8'h10;
    // model results, read only
    localparam logic [AXI_ADDR_W-1:0] ADDR_MN_CNT   = 8'h20;
    localparam logic [AXI_ADDR_W-1:0] ADDR_LL_CNT   = 8'h24;
    localparam logic [AXI_ADDR_W-1:0] ADDR_COMB_CNT = 8'h28;
    localparam logic [AXI_ADDR_W-1:0] ADDR_EMG      = 8'h2C;

    ////////////////////////////////////////////////////////////
    // model types
    ////////////////////////////////////////////////////////////
    typedef logic        [15:0] drive_t;
    typedef logic signed [15:0] gain_t;
    typedef logic signed [31:0] membrane_t;
    typedef logic        [15:0] half_cnt_t;
    typedef logic        [31:0] spike_cnt_t;
    typedef logic        [31:0] emg_t;

    // parameter register reset values
    localparam logic      RST_RUN      = 1'b0;
    localparam half_cnt_t RST_HALF_CNT = 16'd4;
    localparam gain_t     RST_GAIN     = 16'sd0;
    localparam membrane_t RST_THRESH   = 32'sd256;
    localparam drive_t    RST_DRIVE    = 16'd0;

endpackage

//--- rtl/neuro_reg_decode.sv
`timescale 1ns/100ps

module neuro_reg_decode (
    input  logic                                i_ep50trig,
    input  logic                                i_reset_global,
    // axi4-lite write channels
    input  logic [neuro_pkg::AXI_ADDR_W-1:0]    i_awaddr,
    input  logic                                i_awvalid,
    output logic                                o_awready,
    input  logic [neuro_pkg::AXI_DATA_W-1:0]    i_wdata,
    input  logic [neuro_pkg::AXI_DATA_W/8-1:0]  i_wstrb,
    input  logic                                i_wvalid,
    output logic                                o_wready,
    output logic                                o_bvalid,
    output neuro_pkg::axi_resp_t                o_bresp,
    input  logic                                i_bready,
    // axi4-lite read channels
    input  logic [neuro_pkg::AXI_ADDR_W-1:0]    i_araddr,
    input  logic                                i_arvalid,
    output logic                                o_arready,
    output logic                                o_rvalid,
    output logic [neuro_pkg::AXI_DATA_W-1:0]    o_rdata,
    output neuro_pkg::axi_resp_t                o_rresp,
    input  logic                                i_rready,
    // model parameters
    output logic                                o_run,
    output neuro_pkg::half_cnt_t                o_half_cnt,
    output neuro_pkg::gain_t                    o_gain,
    output neuro_pkg::membrane_t                o_thresh,
    output neuro_pkg::drive_t                   o_drive,
    // model results
    input  neuro_pkg::spike_cnt_t               i_mn_cnt,
    input  neuro_pkg::spike_cnt_t               i_ll_cnt,
    input  neuro_pkg::spike_cnt_t               i_comb_cnt,
    input  neuro_pkg::emg_t                     i_emg
);

    logic [neuro_pkg::AXI_DATA_W-1:0] wr_old;
    logic [neuro_pkg::AXI_DATA_W-1:0] wr_merged;
    logic                             wr_err;
    logic [neuro_pkg::AXI_DATA_W-1:0] rd_mux;
    logic                             rd_err;

    ////////////////////////////////////////////////////////////
    // write decode
    ////////////////////////////////////////////////////////////
    // current value of the addressed register, then byte merge
    always_comb
    begin
        wr_old = '0;
        wr_err = 1'b0;
        case (i_awaddr)
            neuro_pkg::ADDR_CTRL:     wr_old[0]    = o_run;
            neuro_pkg::ADDR_HALF_CNT: wr_old[15:0] = o_half_cnt;
            neuro_pkg::ADDR_GAIN:     wr_old[15:0] = o_gain;
            neuro_pkg::ADDR_THRESH:   wr_old       = o_thresh;
            neuro_pkg::ADDR_DRIVE:    wr_old[15:0] = o_drive;
            // result offsets and holes alike
            default:                  wr_err       = 1'b1;
        endcase
        for (int b = 0; b < neuro_pkg::AXI_DATA_W / 8; b++)
        begin
            wr_merged[8*b +: 8] = i_wstrb[b] ? i_wdata[8*b +: 8] : wr_old[8*b +: 8];
        end
    end

    // write fsm, accept both channels together, then respond
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
        begin
            o_awready  <= 1'b0;
            o_wready   <= 1'b0;
            o_bvalid   <= 1'b0;
            o_bresp    <= neuro_pkg::RESP_OKAY;
            o_run      <= neuro_pkg::RST_RUN;
            o_half_cnt <= neuro_pkg::RST_HALF_CNT;
            o_gain     <= neuro_pkg::RST_GAIN;
            o_thresh   <= neuro_pkg::RST_THRESH;
            o_drive    <= neuro_pkg::RST_DRIVE;
        end
        else
        begin
            // ready is a one cycle pulse
            o_awready <= 1'b0;
            o_wready  <= 1'b0;
            if (!o_awready && !o_bvalid && i_awvalid && i_wvalid)
            begin
                o_awready <= 1'b1;
                o_wready  <= 1'b1;
            end
            if (o_awready)
            begin
                o_bvalid <= 1'b1;
                o_bresp  <= wr_err ? neuro_pkg::RESP_SLVERR : neuro_pkg::RESP_OKAY;
                case (i_awaddr)
                    neuro_pkg::ADDR_CTRL:     o_run      <= wr_merged[0];
                    neuro_pkg::ADDR_HALF_CNT: o_half_cnt <= wr_merged[15:0];
                    neuro_pkg::ADDR_GAIN:     o_gain     <= wr_merged[15:0];
                    neuro_pkg::ADDR_THRESH:   o_thresh   <= wr_merged;
                    neuro_pkg::ADDR_DRIVE:    o_drive    <= wr_merged[15:0];
                    default:                  o_run      <= o_run;
                endcase
            end
            else if (o_bvalid && i_bready)
            begin
                o_bvalid <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read path
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        rd_mux = '0;
        rd_err = 1'b0;
        case (i_araddr)
            neuro_pkg::ADDR_CTRL:     rd_mux[0]    = o_run;
            neuro_pkg::ADDR_HALF_CNT: rd_mux[15:0] = o_half_cnt;
            neuro_pkg::ADDR_GAIN:     rd_mux[15:0] = o_gain;
            neuro_pkg::ADDR_THRESH:   rd_mux       = o_thresh;
            neuro_pkg::ADDR_DRIVE:    rd_mux[15:0] = o_drive;
            neuro_pkg::ADDR_MN_CNT:   rd_mux       = i_mn_cnt;
            neuro_pkg::ADDR_LL_CNT:   rd_mux       = i_ll_cnt;
            neuro_pkg::ADDR_COMB_CNT: rd_mux       = i_comb_cnt;
            neuro_pkg::ADDR_EMG:      rd_mux       = i_emg;
            // unmapped, data stays 0
            default:                  rd_err       = 1'b1;
        endcase
    end

    // read fsm, one address at a time
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
        begin
            o_arready <= 1'b0;
            o_rvalid  <= 1'b0;
            o_rresp   <= neuro_pkg::RESP_OKAY;
        end
        else
        begin
            o_arready <= !o_arready && !o_rvalid && i_arvalid;
            if (o_arready)
            begin
                o_rvalid <= 1'b1;
                o_rresp  <= rd_err ? neuro_pkg::RESP_SLVERR : neuro_pkg::RESP_OKAY;
            end
            else if (o_rvalid && i_rready)
            begin
                o_rvalid <= 1'b0;
            end
        end
    end

    // data held here while the host stalls
    always_ff @(posedge i_ep50trig)
    begin
        if (o_arready)
        begin
            o_rdata <= rd_mux;
        end
    end

endmodule

//--- rtl/neuro_spike_emg.sv
`timescale 1ns/100ps

module neuro_spike_emg #(
    parameter int EMG_SHIFT = 3
) (
    input  logic                  i_ep50trig,
    input  logic                  i_reset_global,
    input  logic                  i_run,
    input  logic                  i_tick,
    input  logic                  i_mn_spike,
    input  logic                  i_ll_spike,
    output neuro_pkg::spike_cnt_t o_mn_cnt,
    output neuro_pkg::spike_cnt_t o_ll_cnt,
    output neuro_pkg::spike_cnt_t o_comb_cnt,
    output neuro_pkg::emg_t       o_emg
);

    logic                  ll_meta_q;
    logic                  ll_sync_q;
    logic [2:0]            train;
    neuro_pkg::spike_cnt_t run_cnt [3];
    neuro_pkg::spike_cnt_t cap_cnt [3];
    neuro_pkg::spike_cnt_t comb_total;
    neuro_pkg::emg_t       emg_q;

    ////////////////////////////////////////////////////////////
    // long latency input sync
    ////////////////////////////////////////////////////////////
    // external pin, two flops
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
        begin
            ll_meta_q <= 1'b0;
            ll_sync_q <= 1'b0;
        end
        else
        begin
            ll_meta_q <= i_ll_spike;
            ll_sync_q <= ll_meta_q;
        end
    end

    // 0 mn, 1 ll, 2 combined
    // or, so coincident spikes count once
    assign train = {i_mn_spike | ll_sync_q, ll_sync_q, i_mn_spike};

    ////////////////////////////////////////////////////////////
    // window counters and emg
    ////////////////////////////////////////////////////////////
    // window total includes the tick cycle
    assign comb_total = run_cnt[2] + 32'(train[2]);

    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global || !i_run)
        begin
            for (int k = 0; k < 3; k++)
            begin
                run_cnt[k] <= '0;
                cap_cnt[k] <= '0;
            end
            emg_q <= '0;
        end
        else
        begin
            for (int k = 0; k < 3; k++)
            begin
                if (i_tick)
                begin
                    // capture and restart
                    cap_cnt[k] <= run_cnt[k] + 32'(train[k]);
                    run_cnt[k] <= '0;
                end
                else
                begin
                    run_cnt[k] <= run_cnt[k] + 32'(train[k]);
                end
            end
            // leaky integrator on the combined count
            if (i_tick)
            begin
                emg_q <= emg_q - (emg_q >> EMG_SHIFT) + comb_total;
            end
        end
    end

    assign o_mn_cnt   = cap_cnt[0];
    assign o_ll_cnt   = cap_cnt[1];
    assign o_comb_cnt = cap_cnt[2];
    assign o_emg      = emg_q;

endmodule

//--- rtl/neuro_tick_gen.sv
`timescale 1ns/100ps

module neuro_tick_gen (
    input  logic                 i_ep50trig,
    input  logic                 i_reset_global,
    input  logic                 i_run,
    input  neuro_pkg::half_cnt_t i_half_cnt,
    output logic                 o_tick
);

    neuro_pkg::half_cnt_t half_eff;
    logic [16:0]          last_cnt;
    logic [16:0]          cnt_q;

    // zero guard, period is 2 x half count
    assign half_eff = (i_half_cnt == '0) ? 16'd1 : i_half_cnt;
    assign last_cnt = {half_eff, 1'b0} - 17'd1;

    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global || !i_run)
        begin
            cnt_q  <= '0;
            o_tick <= 1'b0;
        end
        // >= so a shorter period written mid-window still wraps
        else if (cnt_q >= last_cnt)
        begin
            cnt_q  <= '0;
            o_tick <= 1'b1;
        end
        else
        begin
            cnt_q  <= cnt_q + 17'd1;
            o_tick <= 1'b0;
        end
    end

endmodule

//--- tests/neuro_tb_tasks.svh
////////////////////////////////////////////////////////////
// failure reporting and typed compares
////////////////////////////////////////////////////////////
task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
endtask

task automatic check_count(input string name, input neuro_pkg::spike_cnt_t exp_v,
                           input neuro_pkg::spike_cnt_t act_v);
    if (act_v !== exp_v)
    begin
        report_fail($sformatf("Fail %s: expected %0d actual %0d", name, exp_v, act_v));
    end
endtask

task automatic check_emg(input string name, input neuro_pkg::emg_t exp_v,
                         input neuro_pkg::emg_t act_v);
    if (act_v !== exp_v)
    begin
        report_fail($sformatf("Fail %s: expected %0d actual %0d", name, exp_v, act_v));
    end
endtask

task automatic check_resp(input string name, input neuro_pkg::axi_resp_t exp_v,
                          input neuro_pkg::axi_resp_t act_v);
    if (act_v !== exp_v)
    begin
        report_fail($sformatf("Fail %s: expected resp %b actual resp %b", name, exp_v, act_v));
    end
endtask

// raw register word
task automatic check_data(input string name, input logic [neuro_pkg::AXI_DATA_W-1:0] exp_v,
                          input logic [neuro_pkg::AXI_DATA_W-1:0] act_v);
    if (act_v !== exp_v)
    begin
        report_fail($sformatf("Fail %s: expected %h actual %h", name, exp_v, act_v));
    end
endtask

////////////////////////////////////////////////////////////
// axi4-lite bus tasks
////////////////////////////////////////////////////////////
task automatic wait_cycles(input int n);
    repeat (n) @(negedge ep50trig);
endtask

// addr and data held until the response shows
task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, output neuro_pkg::axi_resp_t resp);
    int guard;
    @(negedge ep50trig);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    guard   = 0;
    do
    begin
        @(negedge ep50trig);
        guard++;
        if (guard > 50)
        begin
            report_fail("write address and data were never accepted");
        end
    end while (!awready);
    if (!wready)
    begin
        report_fail("write data ready did not rise with the address ready");
    end
    @(negedge ep50trig);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    guard   = 0;
    while (!bvalid)
    begin
        @(negedge ep50trig);
        guard++;
        if (guard > 50)
        begin
            report_fail("write response never came");
        end
    end
    resp = bresp;
    @(negedge ep50trig);
    bready = 1'b0;
endtask

// four falling edges when stall is 0
task automatic axi_read(input logic [7:0] addr, input int stall,
                        output logic [31:0] data, output logic [31:0] held,
                        output neuro_pkg::axi_resp_t resp);
    int guard;
    @(negedge ep50trig);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b0;
    guard   = 0;
    do
    begin
        @(negedge ep50trig);
        guard++;
        if (guard > 50)
        begin
            report_fail("read address was never accepted");
        end
    end while (!arready);
    @(negedge ep50trig);
    arvalid = 1'b0;
    if (!rvalid)
    begin
        report_fail("read data valid missing one cycle after address accept");
    end
    data = rdata;
    resp = rresp;
    // host stall, data must sit still
    repeat (stall) @(negedge ep50trig);
    if (!rvalid)
    begin
        report_fail("read data valid dropped during the stall");
    end
    held   = rdata;
    rready = 1'b1;
    @(negedge ep50trig);
    rready = 1'b0;
endtask

task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    neuro_pkg::axi_resp_t resp;
    axi_write(addr, data, 4'hF, resp);
    check_resp("register write", neuro_pkg::RESP_OKAY, resp);
endtask

task automatic read_word(input string name, input logic [7:0] addr, output logic [31:0] data);
    logic [31:0]          held;
    neuro_pkg::axi_resp_t resp;
    axi_read(addr, 0, data, held, resp);
    check_resp(name, neuro_pkg::RESP_OKAY, resp);
endtask

task automatic check_readback(input string name, input logic [7:0] addr, input logic [31:0] mask);
    logic [31:0] val;
    logic [31:0] data;
    val = lcg_next();
    write_reg(addr, val);
    read_word(name, addr, data);
    check_data(name, val & mask, data);
endtask

////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////
task automatic test_registers();
    logic [31:0]          val;
    logic [31:0]          part;
    logic [31:0]          data;
    logic [31:0]          held;
    neuro_pkg::axi_resp_t resp;
    if (awready || wready || bvalid || arready || rvalid || spike_out)
    begin
        report_fail("a handshake output or the spike output is high after reset");
    end
    read_word("mn count after reset", neuro_pkg::ADDR_MN_CNT, data);
    check_count("mn count after reset", 32'd0, data);
    read_word("emg after reset", neuro_pkg::ADDR_EMG, data);
    check_emg("emg after reset", 32'd0, data);
    check_readback("ctrl readback", neuro_pkg::ADDR_CTRL, 32'h0000_0001);
    check_readback("half count readback", neuro_pkg::ADDR_HALF_CNT, 32'h0000_FFFF);
    check_readback("gain readback", neuro_pkg::ADDR_GAIN, 32'h0000_FFFF);
    check_readback("threshold readback", neuro_pkg::ADDR_THRESH, 32'hFFFF_FFFF);
    check_readback("drive readback", neuro_pkg::ADDR_DRIVE, 32'h0000_FFFF);
    // bytes 1 and 3 keep the old value
    val  = lcg_next();
    part = lcg_next();
    write_reg(neuro_pkg::ADDR_THRESH, val);
    axi_write(neuro_pkg::ADDR_THRESH, part, 4'b0101, resp);
    check_resp("partial strobe write", neuro_pkg::RESP_OKAY, resp);
    read_word("partial strobe", neuro_pkg::ADDR_THRESH, data);
    check_data("partial strobe", {val[31:24], part[23:16], val[15:8], part[7:0]}, data);
    // hole in the map
    axi_read(8'h40, 0, data, held, resp);
    check_resp("unmapped read", neuro_pkg::RESP_SLVERR, resp);
    check_data("unmapped read", 32'd0, data);
    axi_write(neuro_pkg::ADDR_MN_CNT, lcg_next(), 4'hF, resp);
    check_resp("write to mn count", neuro_pkg::RESP_SLVERR, resp);
    write_reg(neuro_pkg::ADDR_CTRL, 32'd0);
endtask

task automatic test_silent();
    logic [31:0] r;
    logic [31:0] data;
    int          h;
    r = lcg_next();
    h = r[2:0] + 1;
    write_reg(neuro_pkg::ADDR_HALF_CNT, h);
    write_reg(neuro_pkg::ADDR_GAIN, 32'd0);
    write_reg(neuro_pkg::ADDR_THRESH, 32'd256);
    write_reg(neuro_pkg::ADDR_DRIVE, {16'd0, r[31:16]});
    spike_seen  = 1'b0;
    spike_watch = 1'b1;
    write_reg(neuro_pkg::ADDR_CTRL, 32'd1);
    // random ll noise must not reach the mn train
    repeat (16 * h)
    begin
        @(negedge ep50trig);
        r        = lcg_next();
        spike_in = r[16];
    end
    spike_in    = 1'b0;
    spike_watch = 1'b0;
    read_word("silent neuron", neuro_pkg::ADDR_MN_CNT, data);
    check_count("silent neuron", 32'd0, data);
    if (spike_seen)
    begin
        report_fail("o_spike_out rose while the gain was 0");
    end
    write_reg(neuro_pkg::ADDR_CTRL, 32'd0);
endtask

// drive x gain = threshold, so a spike every cycle
task automatic set_fire_every_cycle();
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] g;
    r = lcg_next();
    d = r[7:0] + 1;
    g = r[22:16] + 1;
    write_reg(neuro_pkg::ADDR_DRIVE, d);
    write_reg(neuro_pkg::ADDR_THRESH, d * g);
    write_reg(neuro_pkg::ADDR_GAIN, g);
endtask

task automatic test_fire();
    logic [31:0] r;
    logic [31:0] data;
    int          h;
    int          heff;
    set_fire_every_cycle();
    for (int i = 0; i < 5; i++)
    begin
        r    = lcg_next();
        // first pass covers the zero guard
        h    = (i == 0) ? 0 : r[2:0] + 1;
        heff = (h == 0) ? 1 : h;
        write_reg(neuro_pkg::ADDR_CTRL, 32'd0);
        write_reg(neuro_pkg::ADDR_HALF_CNT, h);
        write_reg(neuro_pkg::ADDR_CTRL, 32'd1);
        wait_cycles(6 * heff + 8);
        read_word("fire every cycle", neuro_pkg::ADDR_MN_CNT, data);
        check_count($sformatf("fire every cycle half %0d", h), 2 * heff, data);
    end
    write_reg(neuro_pkg::ADDR_CTRL, 32'd0);
endtask

task automatic test_long_latency();
    logic [31:0] r;
    logic [31:0] data;
    int          h;
    r = lcg_next();
    h = r[2:0] + 1;
    write_reg(neuro_pkg::ADDR_HALF_CNT, h);
    write_reg(neuro_pkg::ADDR_GAIN, 32'd0);
    write_reg(neuro_pkg::ADDR_THRESH, 32'd256);
    spike_in = 1'b1;
    write_reg(neuro_pkg::ADDR_CTRL, 32'd1);
    wait_cycles(6 * h + 8);
    read_word("ll count", neuro_pkg::ADDR_LL_CNT, data);
    check_count("ll count", 2 * h, data);
    read_word("combined count", neuro_pkg::ADDR_COMB_CNT, data);
    check_count("combined count", 2 * h, data);
    // both trains high, or must not double count
    set_fire_every_cycle();
    wait_cycles(6 * h + 8);
    read_word("combined count both", neuro_pkg::ADDR_COMB_CNT, data);
    check_count("combined count both", 2 * h, data);
    read_word("mn count both", neuro_pkg::ADDR_MN_CNT, data);
    check_count("mn count both", 2 * h, data);
    spike_in = 1'b0;
    write_reg(neuro_pkg::ADDR_CTRL, 32'd0);
endtask

task automatic test_emg();
    logic [31:0]          r;
    logic [31:0]          data;
    logic [31:0]          held;
    neuro_pkg::axi_resp_t resp;
    neuro_pkg::emg_t      emg_exp;
    int                   h;
    r = lcg_next();
    // at least 4, so a read fits before the first tick
    h = r[1:0] + 4;
    write_reg(neuro_pkg::ADDR_HALF_CNT, h);
    set_fire_every_cycle();
    write_reg(neuro_pkg::ADDR_CTRL, 32'd1);
    emg_exp = '0;
    read_word("emg step 0", neuro_pkg::ADDR_EMG, data);
    check_emg("emg step 0", emg_exp, data);
    // reads spaced one window apart see exactly one update each
    for (int k = 1; k <= 6; k++)
    begin
        wait_cycles(2 * h - 4);
        read_word("emg step", neuro_pkg::ADDR_EMG, data);
        emg_exp = emg_exp - (emg_exp >> EMG_SHIFT) + 2 * h;
        check_emg($sformatf("emg step %0d", k), emg_exp, data);
    end
    // stall spans a full window, so the live emg moves meanwhile
    axi_read(neuro_pkg::ADDR_EMG, 2 * h, data, held, resp);
    check_resp("read hold", neuro_pkg::RESP_OKAY, resp);
    check_emg("read hold", emg_exp, data);
    check_emg("read hold stalled", emg_exp, held);
endtask

task automatic test_run_clear();
    logic [31:0] data;
    write_reg(neuro_pkg::ADDR_CTRL, 32'd0);
    // long window, all reads land before the first tick
    write_reg(neuro_pkg::ADDR_HALF_CNT, 32'd16);
    write_reg(neuro_pkg::ADDR_CTRL, 32'd1);
    read_word("run clear mn", neuro_pkg::ADDR_MN_CNT, data);
    check_count("run clear mn", 32'd0, data);
    read_word("run clear ll", neuro_pkg::ADDR_LL_CNT, data);
    check_count("run clear ll", 32'd0, data);
    read_word("run clear combined", neuro_pkg::ADDR_COMB_CNT, data);
    check_count("run clear combined", 32'd0, data);
    read_word("run clear emg", neuro_pkg::ADDR_EMG, data);
    check_emg("run clear emg", 32'd0, data);
    write_reg(neuro_pkg::ADDR_CTRL, 32'd0);
endtask

//--- tests/neuro_tb.sv
`timescale 1ns/100ps

module neuro_tb;

    localparam int EMG_SHIFT = 3;
    // cycle budget per test, registers to run clear
    localparam int RUN_CYCLES = 200 + 300 + 500 + 300 + 300 + 100;
    localparam int MARGIN_CYCLES = 500;

    logic                                ep50trig;
    logic                                reset_global;
    logic [neuro_pkg::AXI_ADDR_W-1:0]    awaddr;
    logic                                awvalid;
    logic                                awready;
    logic [neuro_pkg::AXI_DATA_W-1:0]    wdata;
    logic [neuro_pkg::AXI_DATA_W/8-1:0]  wstrb;
    logic                                wvalid;
    logic                                wready;
    logic                                bvalid;
    neuro_pkg::axi_resp_t                bresp;
    logic                                bready;
    logic [neuro_pkg::AXI_ADDR_W-1:0]    araddr;
    logic                                arvalid;
    logic                                arready;
    logic                                rvalid;
    logic [neuro_pkg::AXI_DATA_W-1:0]    rdata;
    neuro_pkg::axi_resp_t                rresp;
    logic                                rready;
    logic                                spike_in;
    logic                                spike_out;
    // lcg state and spike monitor flags
    logic [31:0]                         lcg_state;
    logic                                spike_watch;
    logic                                spike_seen;

    neuro_emu_top #(
        .EMG_SHIFT (EMG_SHIFT)
    ) neuro_emu_top_inst (
        .i_ep50trig     (ep50trig),
        .i_reset_global (reset_global),
        .i_awaddr       (awaddr),
        .i_awvalid      (awvalid),
        .o_awready      (awready),
        .i_wdata        (wdata),
        .i_wstrb        (wstrb),
        .i_wvalid       (wvalid),
        .o_wready       (wready),
        .o_bvalid       (bvalid),
        .o_bresp        (bresp),
        .i_bready       (bready),
        .i_araddr       (araddr),
        .i_arvalid      (arvalid),
        .o_arready      (arready),
        .o_rvalid       (rvalid),
        .o_rdata        (rdata),
        .o_rresp        (rresp),
        .i_rready       (rready),
        .i_spike_in     (spike_in),
        .o_spike_out    (spike_out)
    );

    // 8 ns period
    always #4 ep50trig = ~ep50trig;

    // catch any motoneuron spike while watched
    always @(negedge ep50trig)
    begin
        if (spike_watch && spike_out)
        begin
            spike_seen = 1'b1;
        end
    end

    // numerical recipes lcg
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    `include "neuro_tb_tasks.svh"

    ////////////////////////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////////////////////////
    initial
    begin
        #((RUN_CYCLES + MARGIN_CYCLES) * 8);
        report_fail("watchdog expired, the test sequence did not finish in time");
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        ep50trig     = 1'b0;
        reset_global = 1'b1;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        spike_in     = 1'b0;
        spike_watch  = 1'b0;
        spike_seen   = 1'b0;
        lcg_state    = 32'd79;
        // reset for 8 cycles, released on a falling edge
        repeat (8) @(negedge ep50trig);
        reset_global = 1'b0;
        test_registers();
        test_silent();
        test_fire();
        test_long_latency();
        test_emg();
        test_run_clear();
        $display("TB PASSED");
        $finish;
    end

endmodule
